/* src/mips_pkg.sv */
package mips_pkg;

   // widths
   localparam int nb_data     = 32;
   localparam int nb_reg      = 5;
   localparam int nb_function = 6;
   localparam int nb_alu_op   = 3;
   localparam int nb_ope      = 4;

   // opcodes
   localparam logic [5:0] op_rtype = 6'h00;
   localparam logic [5:0] op_jal   = 6'h03;
   localparam logic [5:0] op_addi  = 6'h08;
   localparam logic [5:0] op_slti  = 6'h0a;
   localparam logic [5:0] op_andi  = 6'h0c;
   localparam logic [5:0] op_ori   = 6'h0d;

   // r-type function field
   localparam logic [nb_function-1:0] fn_sll = 6'h00;
   localparam logic [nb_function-1:0] fn_srl = 6'h02;
   localparam logic [nb_function-1:0] fn_add = 6'h20;
   localparam logic [nb_function-1:0] fn_sub = 6'h22;
   localparam logic [nb_function-1:0] fn_and = 6'h24;
   localparam logic [nb_function-1:0] fn_or  = 6'h25;
   localparam logic [nb_function-1:0] fn_xor = 6'h26;
   localparam logic [nb_function-1:0] fn_nor = 6'h27;
   localparam logic [nb_function-1:0] fn_slt = 6'h2a;

   // control class out of decode
   localparam logic [nb_alu_op-1:0] aop_rtype = 3'd0;
   localparam logic [nb_alu_op-1:0] aop_add   = 3'd1;
   localparam logic [nb_alu_op-1:0] aop_and   = 3'd2;
   localparam logic [nb_alu_op-1:0] aop_or    = 3'd3;
   localparam logic [nb_alu_op-1:0] aop_slt   = 3'd4;

   localparam logic [nb_ope-1:0] ope_add = 4'd0;
   localparam logic [nb_ope-1:0] ope_sub = 4'd1;
   localparam logic [nb_ope-1:0] ope_and = 4'd2;
   localparam logic [nb_ope-1:0] ope_or  = 4'd3;
   localparam logic [nb_ope-1:0] ope_xor = 4'd4;
   localparam logic [nb_ope-1:0] ope_nor = 4'd5;
   localparam logic [nb_ope-1:0] ope_slt = 4'd6;
   localparam logic [nb_ope-1:0] ope_sll = 4'd7;
   localparam logic [nb_ope-1:0] ope_srl = 4'd8;

   // operand and destination selects
   localparam logic [1:0] pc_to_a        = 2'd0;
   localparam logic [1:0] rs_to_a        = 2'd1;
   localparam logic [1:0] sext_to_a      = 2'd2;
   localparam logic       rt_to_b        = 1'b0;
   localparam logic       sext_to_b      = 1'b1;
   localparam logic [1:0] from_id_ex     = 2'd0;
   localparam logic [1:0] from_ex_mem    = 2'd1;
   localparam logic [1:0] from_mem_wb    = 2'd2;
   localparam logic [1:0] dest_from_rd   = 2'd0;
   localparam logic [1:0] dest_from_rt   = 2'd1;
   localparam logic [1:0] dest_to_return = 2'd2;

   localparam logic [nb_reg-1:0] return_reg = 5'd31;

   // one instruction word, two views
   typedef union packed {
      struct packed {
         logic [5:0]             opcode;
         logic [nb_reg-1:0]      rs;
         logic [nb_reg-1:0]      rt;
         logic [nb_reg-1:0]      rd;
         logic [4:0]             shamt;
         logic [nb_function-1:0] funct;
      } r_fields;
      struct packed {
         logic [5:0]        opcode;
         logic [nb_reg-1:0] rs;
         logic [nb_reg-1:0] rt;
         logic [15:0]       imm16;
      } i_fields;
   } instr_t;

endpackage

/* src/register_file.sv */
`timescale 1ns/1ns

module register_file
   import mips_pkg::*;
(
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic [nb_reg-1:0]  i_rs_addr,
   input  logic [nb_reg-1:0]  i_rt_addr,
   output logic [nb_data-1:0] o_rs_data,
   output logic [nb_data-1:0] o_rt_data,
   input  logic               i_ex_valid,
   input  logic [nb_reg-1:0]  i_ex_dst,
   input  logic [nb_data-1:0] i_ex_result,
   output logic               o_wb_valid,
   output logic [nb_reg-1:0]  o_wb_dst,
   output logic [nb_data-1:0] o_wb_data
);

   logic [nb_data-1:0] regs [32];

   // mem/wb stage, memory is a plain pass-through here
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_wb_valid <= 1'b0;
      end else begin
         o_wb_valid <= i_ex_valid;
      end
      o_wb_dst  <= i_ex_dst;
      o_wb_data <= i_ex_result;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int k = 0; k < 32; k++) begin
            regs[k] <= '0;
         end
      end else if (o_wb_valid) begin
         regs[o_wb_dst] <= o_wb_data; // dst is never 0 here
      end
   end

   // write-through so decode sees the value being written this cycle
   always_comb begin
      if (i_rs_addr == '0)                         o_rs_data = '0;
      else if (o_wb_valid && i_rs_addr == o_wb_dst) o_rs_data = o_wb_data;
      else                                          o_rs_data = regs[i_rs_addr];
      if (i_rt_addr == '0)                         o_rt_data = '0;
      else if (o_wb_valid && i_rt_addr == o_wb_dst) o_rt_data = o_wb_data;
      else                                          o_rt_data = regs[i_rt_addr];
   end

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage
   import mips_pkg::*;
(
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  logic                   i_instr_valid,
   input  instr_t                 i_instr,
   output logic [nb_reg-1:0]      o_rs_addr,
   output logic [nb_reg-1:0]      o_rt_addr,
   input  logic [nb_data-1:0]     i_rs_data,
   input  logic [nb_data-1:0]     i_rt_data,
   output logic                   o_valid,
   output logic                   o_reg_write,
   output logic [nb_alu_op-1:0]   o_alu_op,
   output logic [1:0]             o_mux_a_ctl,
   output logic                   o_mux_b_ctl,
   output logic [1:0]             o_mux_dest_ctl,
   output logic [nb_reg-1:0]      o_rs,
   output logic [nb_reg-1:0]      o_rt,
   output logic [nb_reg-1:0]      o_rd,
   output logic [nb_function-1:0] o_function,
   output logic [nb_data-1:0]     o_rs_reg,
   output logic [nb_data-1:0]     o_rt_reg,
   output logic [nb_data-1:0]     o_sign_ext,
   output logic [nb_data-1:0]     o_pc_4
);

   logic [nb_data-1:0]   pc;
   logic                 writes;
   logic                 is_shift;
   logic [nb_alu_op-1:0] alu_op;
   logic [1:0]           mux_a;
   logic                 mux_b;
   logic [1:0]           mux_dest;
   logic [nb_reg-1:0]    dst;
   logic [nb_data-1:0]   sign_ext;

   assign o_rs_addr = i_instr.i_fields.rs;
   assign o_rt_addr = i_instr.i_fields.rt;
   assign is_shift  = (i_instr.r_fields.funct == fn_sll) || (i_instr.r_fields.funct == fn_srl);

   always_comb begin
      writes   = 1'b1;
      alu_op   = aop_add;
      mux_a    = rs_to_a;
      mux_b    = sext_to_b;
      mux_dest = dest_from_rt;
      case (i_instr.r_fields.opcode)
         op_rtype: begin
            alu_op   = aop_rtype;
            mux_a    = is_shift ? sext_to_a : rs_to_a; // shamt rides in sext[10:6]
            mux_b    = rt_to_b;
            mux_dest = dest_from_rd;
         end
         op_addi: alu_op = aop_add;
         op_andi: alu_op = aop_and;
         op_ori:  alu_op = aop_or;
         op_slti: alu_op = aop_slt;
         op_jal: begin
            mux_a    = pc_to_a; // pc+4 plus zero
            mux_dest = dest_to_return;
         end
         default: writes = 1'b0;
      endcase
   end

   // only needed here for the register 0 check
   always_comb begin
      case (mux_dest)
         dest_from_rd: dst = i_instr.r_fields.rd;
         dest_from_rt: dst = i_instr.i_fields.rt;
         default:      dst = return_reg;
      endcase
   end

   assign sign_ext = (i_instr.i_fields.opcode == op_jal) ? '0
                   : {{16{i_instr.i_fields.imm16[15]}}, i_instr.i_fields.imm16};

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc          <= '0;
         o_valid     <= 1'b0;
         o_reg_write <= 1'b0;
      end else begin
         if (i_instr_valid) pc <= pc + 32'd4;
         o_valid     <= i_instr_valid;
         o_reg_write <= i_instr_valid && writes && (dst != '0);
      end
   end

   // id/ex payload
   always_ff @(posedge i_clk) begin
      o_alu_op       <= alu_op;
      o_mux_a_ctl    <= mux_a;
      o_mux_b_ctl    <= mux_b;
      o_mux_dest_ctl <= mux_dest;
      o_rs           <= i_instr.r_fields.rs;
      o_rt           <= i_instr.r_fields.rt;
      o_rd           <= i_instr.r_fields.rd;
      o_function     <= i_instr.r_fields.funct;
      o_rs_reg       <= i_rs_data;
      o_rt_reg       <= i_rt_data;
      o_sign_ext     <= sign_ext;
      o_pc_4         <= pc + 32'd4;
   end

endmodule

/* src/alu_control.sv */
`timescale 1ns/1ns

module alu_control
   import mips_pkg::*;
(
   input  logic [nb_alu_op-1:0]   i_alu_op,
   input  logic [nb_function-1:0] i_function,
   output logic [nb_ope-1:0]      o_ope
);

   logic [nb_ope-1:0] fn_ope;

   // r-type, operation comes from the function field
   always_comb begin
      case (i_function)
         fn_add:  fn_ope = ope_add;
         fn_sub:  fn_ope = ope_sub;
         fn_and:  fn_ope = ope_and;
         fn_or:   fn_ope = ope_or;
         fn_xor:  fn_ope = ope_xor;
         fn_nor:  fn_ope = ope_nor;
         fn_slt:  fn_ope = ope_slt;
         fn_sll:  fn_ope = ope_sll;
         fn_srl:  fn_ope = ope_srl;
         default: fn_ope = 4'hf; // alu returns 0
      endcase
   end

   always_comb begin
      case (i_alu_op)
         aop_rtype: o_ope = fn_ope;
         aop_and:   o_ope = ope_and;
         aop_or:    o_ope = ope_or;
         aop_slt:   o_ope = ope_slt;
         default:   o_ope = ope_add; // addi, jal
      endcase
   end

endmodule

/* src/alu.sv */
`timescale 1ns/1ns

module alu
   import mips_pkg::*;
(
   input  logic [nb_data-1:0] i_data_a,
   input  logic [nb_data-1:0] i_data_b,
   input  logic [nb_ope-1:0]  i_ope,
   output logic [nb_data-1:0] o_alu
);

   logic [4:0] shamt;
   logic       less;

   assign shamt = i_data_a[10:6]; // shift amount out of the sign extension
   assign less  = $signed(i_data_a) < $signed(i_data_b);

   always_comb begin
      case (i_ope)
         ope_add: o_alu = i_data_a + i_data_b; // wraps
         ope_sub: o_alu = i_data_a - i_data_b;
         ope_and: o_alu = i_data_a & i_data_b;
         ope_or:  o_alu = i_data_a | i_data_b;
         ope_xor: o_alu = i_data_a ^ i_data_b;
         ope_nor: o_alu = ~(i_data_a | i_data_b);
         ope_slt: o_alu = {{(nb_data - 1){1'b0}}, less};
         ope_sll: o_alu = i_data_b << shamt;
         ope_srl: o_alu = i_data_b >> shamt;
         default: o_alu = '0;
      endcase
   end

endmodule

/* src/forwarding_unit.sv */
`timescale 1ns/1ns

module forwarding_unit
   import mips_pkg::*;
(
   input  logic [nb_reg-1:0] i_rs,
   input  logic [nb_reg-1:0] i_rt,
   input  logic              i_ex_mem_valid,
   input  logic [nb_reg-1:0] i_ex_mem_dst,
   input  logic              i_mem_wb_valid,
   input  logic [nb_reg-1:0] i_mem_wb_dst,
   output logic [1:0]        o_mux_a_hz,
   output logic [1:0]        o_mux_b_hz
);

   // valid already includes reg_write, and dst 0 never gets it
   function automatic logic [1:0] hz_sel(input logic [nb_reg-1:0] src);
      logic [1:0] sel;
      sel = from_id_ex;
      if (i_ex_mem_valid && i_ex_mem_dst == src) begin
         sel = from_ex_mem; // youngest result wins
      end else if (i_mem_wb_valid && i_mem_wb_dst == src) begin
         sel = from_mem_wb;
      end
      return sel;
   endfunction

   always_comb begin
      o_mux_a_hz = hz_sel(i_rs);
      o_mux_b_hz = hz_sel(i_rt);
   end

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage
   import mips_pkg::*;
(
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  logic                   i_valid,
   input  logic                   i_reg_write,
   input  logic [nb_alu_op-1:0]   i_alu_op,
   input  logic [1:0]             i_mux_a_ctl,
   input  logic                   i_mux_b_ctl,
   input  logic [1:0]             i_mux_dest_ctl,
   input  logic [nb_reg-1:0]      i_rt,
   input  logic [nb_reg-1:0]      i_rd,
   input  logic [nb_function-1:0] i_function,
   input  logic [nb_data-1:0]     i_rs_reg,
   input  logic [nb_data-1:0]     i_rt_reg,
   input  logic [nb_data-1:0]     i_sign_ext,
   input  logic [nb_data-1:0]     i_pc_4,
   input  logic [1:0]             i_mux_a_hz,
   input  logic [1:0]             i_mux_b_hz,
   input  logic [nb_data-1:0]     i_mem_wb_data,
   output logic                   o_valid,
   output logic [nb_reg-1:0]      o_dst,
   output logic [nb_data-1:0]     o_result
);

   logic [nb_ope-1:0]  ope;
   logic [nb_data-1:0] rs_fwd;
   logic [nb_data-1:0] rt_fwd;
   logic [nb_data-1:0] data_a;
   logic [nb_data-1:0] data_b;
   logic [nb_data-1:0] alu_out;
   logic [nb_reg-1:0]  dst;

   function automatic logic [nb_data-1:0] fwd(input logic [1:0] sel,
                                              input logic [nb_data-1:0] reg_data);
      case (sel)
         from_ex_mem: return o_result;
         from_mem_wb: return i_mem_wb_data;
         default:     return reg_data;
      endcase
   endfunction

   // forward into register data only, so pc+4 and immediates stay put
   always_comb begin
      rs_fwd = fwd(i_mux_a_hz, i_rs_reg);
      rt_fwd = fwd(i_mux_b_hz, i_rt_reg);
   end

   always_comb begin
      case (i_mux_a_ctl)
         pc_to_a:   data_a = i_pc_4;
         sext_to_a: data_a = i_sign_ext;
         default:   data_a = rs_fwd;
      endcase
      case (i_mux_dest_ctl)
         dest_from_rt:   dst = i_rt;
         dest_to_return: dst = return_reg;
         default:        dst = i_rd;
      endcase
   end

   assign data_b = (i_mux_b_ctl == sext_to_b) ? i_sign_ext : rt_fwd;

   alu_control u_alu_control (
      .i_alu_op   (i_alu_op),
      .i_function (i_function),
      .o_ope      (ope)
   );

   alu u_alu (
      .i_data_a (data_a),
      .i_data_b (data_b),
      .i_ope    (ope),
      .o_alu    (alu_out)
   );

   // ex/mem
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_valid <= 1'b0;
      end else begin
         o_valid <= i_valid && i_reg_write; // only real writes go on
      end
      o_dst    <= dst;
      o_result <= alu_out;
   end

endmodule

/* src/mips_ex_core.sv */
`timescale 1ns/1ns

module mips_ex_core
   import mips_pkg::*;
(
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_instr_valid,
   input  instr_t             i_instr,
   output logic               o_wb_valid,
   output logic [nb_reg-1:0]  o_wb_dst,
   output logic [nb_data-1:0] o_wb_data
);

   logic [nb_reg-1:0]      rs_addr, rt_addr;
   logic [nb_data-1:0]     rs_data, rt_data;
   logic                   id_valid, id_reg_write, id_mux_b_ctl;
   logic [nb_alu_op-1:0]   id_alu_op;
   logic [1:0]             id_mux_a_ctl, id_mux_dest_ctl;
   logic [nb_reg-1:0]      id_rs, id_rt, id_rd;
   logic [nb_function-1:0] id_function;
   logic [nb_data-1:0]     id_rs_reg, id_rt_reg, id_sign_ext, id_pc_4;
   logic                   ex_valid;
   logic [nb_reg-1:0]      ex_dst;
   logic [nb_data-1:0]     ex_result;
   logic [1:0]             mux_a_hz, mux_b_hz;

   decode_stage u_decode (
      .i_clk (i_clk), .i_rst (i_rst),
      .i_instr_valid (i_instr_valid), .i_instr (i_instr),
      .o_rs_addr (rs_addr), .o_rt_addr (rt_addr),
      .i_rs_data (rs_data), .i_rt_data (rt_data),
      .o_valid (id_valid), .o_reg_write (id_reg_write), .o_alu_op (id_alu_op),
      .o_mux_a_ctl (id_mux_a_ctl), .o_mux_b_ctl (id_mux_b_ctl),
      .o_mux_dest_ctl (id_mux_dest_ctl),
      .o_rs (id_rs), .o_rt (id_rt), .o_rd (id_rd), .o_function (id_function),
      .o_rs_reg (id_rs_reg), .o_rt_reg (id_rt_reg),
      .o_sign_ext (id_sign_ext), .o_pc_4 (id_pc_4)
   );

   register_file u_register_file (
      .i_clk (i_clk), .i_rst (i_rst),
      .i_rs_addr (rs_addr), .i_rt_addr (rt_addr),
      .o_rs_data (rs_data), .o_rt_data (rt_data),
      .i_ex_valid (ex_valid), .i_ex_dst (ex_dst), .i_ex_result (ex_result),
      .o_wb_valid (o_wb_valid), .o_wb_dst (o_wb_dst), .o_wb_data (o_wb_data)
   );

   forwarding_unit u_forwarding (
      .i_rs (id_rs), .i_rt (id_rt),
      .i_ex_mem_valid (ex_valid), .i_ex_mem_dst (ex_dst),
      .i_mem_wb_valid (o_wb_valid), .i_mem_wb_dst (o_wb_dst),
      .o_mux_a_hz (mux_a_hz), .o_mux_b_hz (mux_b_hz)
   );

   execute_stage u_execute (
      .i_clk (i_clk), .i_rst (i_rst),
      .i_valid (id_valid), .i_reg_write (id_reg_write), .i_alu_op (id_alu_op),
      .i_mux_a_ctl (id_mux_a_ctl), .i_mux_b_ctl (id_mux_b_ctl),
      .i_mux_dest_ctl (id_mux_dest_ctl),
      .i_rt (id_rt), .i_rd (id_rd), .i_function (id_function),
      .i_rs_reg (id_rs_reg), .i_rt_reg (id_rt_reg),
      .i_sign_ext (id_sign_ext), .i_pc_4 (id_pc_4),
      .i_mux_a_hz (mux_a_hz), .i_mux_b_hz (mux_b_hz), .i_mem_wb_data (o_wb_data),
      .o_valid (ex_valid), .o_dst (ex_dst), .o_result (ex_result)
   );

endmodule

/* test/mips_ex_core_properties.sv */
`timescale 1ns/1ns

module mips_ex_core_properties
   import mips_pkg::*;
(
   input logic              i_clk,
   input logic              i_rst,
   input logic              i_instr_valid,
   input logic              i_id_valid,
   input logic              i_id_reg_write,
   input logic              i_wb_valid,
   input logic [nb_reg-1:0] i_wb_dst
);

   // pipe comes out of reset empty
   a_quiet_after_reset: assert property (@(posedge i_clk) $fell(i_rst) |=> !i_wb_valid)
      else $error("o_wb_valid high in the cycle after reset");

   a_no_r0_write: assert property (@(posedge i_clk) disable iff (i_rst)
      i_wb_valid |-> i_wb_dst != '0)
      else $error("write-back to register 0");

   // id/ex write shows up two edges later on o_wb
   a_write_latency: assert property (@(posedge i_clk) disable iff (i_rst)
      $past(i_id_valid && i_id_reg_write, 2) |-> i_wb_valid)
      else $error("accepted write missing on o_wb_valid after 3 edges");

   a_write_source: assert property (@(posedge i_clk) disable iff (i_rst)
      i_wb_valid |-> $past(i_instr_valid, 3))
      else $error("o_wb_valid without an instruction accepted 3 edges before");

endmodule

bind mips_ex_core mips_ex_core_properties u_properties (
   .i_clk          (i_clk),
   .i_rst          (i_rst),
   .i_instr_valid  (i_instr_valid),
   .i_id_valid     (id_valid),
   .i_id_reg_write (id_reg_write),
   .i_wb_valid     (o_wb_valid),
   .i_wb_dst       (o_wb_dst)
);

/* test/tb_mips_ex_core.sv */
`timescale 1ns/1ns

module tb_mips_ex_core
   import mips_pkg::*;
();

   localparam int n_rand  = 200;
   localparam int n_issue = 12 + 9 + 18 + 4 + 9 + n_rand; // instructions and bubbles
   localparam int limit   = 4 + n_issue + 6 * 7 + 20;   // reset, drain per test, margin

   logic         clk = 1'b0;
   logic         rst;
   logic         instr_valid;
   instr_t       instr;
   logic         wb_valid;
   logic [4:0]   wb_dst;
   logic [31:0]  wb_data;
   integer       seed = 32'h2284;
   int           cycles = 0;
   int           checks = 0;
   int           errors = 0;
   int           checks0;
   int           errors0;
   logic [31:0]  ref_regs [32];
   logic [31:0]  ref_pc;
   logic [4:0]   exp_dst [$];
   logic [31:0]  exp_data [$];
   logic [4:0]   want_dst;
   logic [31:0]  want_data;

   always #4 clk = ~clk;

   mips_ex_core i_mips_ex_core (
      .i_clk         (clk),
      .i_rst         (rst),
      .i_instr_valid (instr_valid),
      .i_instr       (instr),
      .o_wb_valid    (wb_valid),
      .o_wb_dst      (wb_dst),
      .o_wb_data     (wb_data)
   );

   // builds the word for op index n (r-type 0 to 8, immediates 9 to 12, jal 13)
   function automatic instr_t make_word(input int n, input logic [4:0] rs, rt, rd,
                                        input logic [15:0] imm);
      case (n)
         0:       return {op_rtype, rs, rt, rd, 5'd0, fn_add};
         1:       return {op_rtype, rs, rt, rd, 5'd0, fn_sub};
         2:       return {op_rtype, rs, rt, rd, 5'd0, fn_and};
         3:       return {op_rtype, rs, rt, rd, 5'd0, fn_or};
         4:       return {op_rtype, rs, rt, rd, 5'd0, fn_xor};
         5:       return {op_rtype, rs, rt, rd, 5'd0, fn_nor};
         6:       return {op_rtype, rs, rt, rd, 5'd0, fn_slt};
         7:       return {op_rtype, rs, rt, rd, imm[10:6], fn_sll}; // shamt from imm bits
         8:       return {op_rtype, rs, rt, rd, imm[10:6], fn_srl};
         9:       return {op_addi, rs, rt, imm};
         10:      return {op_andi, rs, rt, imm};
         11:      return {op_ori, rs, rt, imm};
         12:      return {op_slti, rs, rt, imm};
         default: return {op_jal, rs, rt, imm};
      endcase
   endfunction

   // reference model applies the word, queues its write, then drives it
   task automatic issue(input instr_t w);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] res;
      logic [4:0]  dst;
      a   = ref_regs[w.r_fields.rs];
      b   = ref_regs[w.r_fields.rt];
      imm = {{16{w.i_fields.imm16[15]}}, w.i_fields.imm16};
      dst = w.i_fields.rt;
      case (w.r_fields.opcode)
         op_addi: res = a + imm;
         op_andi: res = a & imm;
         op_ori:  res = a | imm;
         op_slti: res = {31'd0, $signed(a) < $signed(imm)};
         op_jal: begin
            res = ref_pc + 32'd4; // return address
            dst = return_reg;
         end
         default: begin
            dst = w.r_fields.rd;
            case (w.r_fields.funct)
               fn_add:  res = a + b;
               fn_sub:  res = a - b;
               fn_and:  res = a & b;
               fn_or:   res = a | b;
               fn_xor:  res = a ^ b;
               fn_nor:  res = ~(a | b);
               fn_slt:  res = {31'd0, $signed(a) < $signed(b)};
               fn_sll:  res = b << w.r_fields.shamt;
               default: res = b >> w.r_fields.shamt;
            endcase
         end
      endcase
      if (dst != 5'd0) begin // r0 writes vanish
         ref_regs[dst] = res;
         exp_dst.push_back(dst);
         exp_data.push_back(res);
      end
      ref_pc = ref_pc + 32'd4;
      @(posedge clk);
      instr_valid <= 1'b1;
      instr       <= w;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         instr_valid <= 1'b0;
         // a writing ori to r30 that must be ignored
         instr       <= make_word(11, 5'd0, 5'd30, 5'd0, 16'($random(seed)));
      end
   endtask

   // independent ori writes to r23
   task automatic fill(input int n);
      repeat (n) begin
         issue(make_word(11, 5'd0, 5'd23, 5'd0, 16'($random(seed))));
      end
   endtask

   task automatic end_test(input string name);
      idle(1);
      while (exp_dst.size() != 0) @(posedge clk);
      repeat (3) @(posedge clk); // non-writing tail leaves the pipe
      $display("%s: %0d writes checked, %0d errors", name, checks - checks0, errors - errors0);
      checks0 = checks;
      errors0 = errors;
   endtask

   // write-back checks on the falling edge
   always @(negedge clk) begin
      if (!rst && wb_valid) begin
         assert (exp_dst.size() != 0) else begin
            $display("write-back to r%0d at %0t with nothing expected", wb_dst, $time);
            errors++;
         end
         if (exp_dst.size() != 0) begin
            want_dst  = exp_dst.pop_front();
            want_data = exp_data.pop_front();
            checks++;
            assert (wb_dst == want_dst) else begin
               $display("Fail at %0t: o_wb_dst = %0d, expected %0d", $time, wb_dst, want_dst);
               errors++;
            end
            assert (wb_data == want_data) else begin
               $display("Fail at %0t: o_wb_data = %h, expected %h", $time, wb_data, want_data);
               errors++;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
         $display("timeout after %0d cycles, the pipeline never drained", cycles);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   initial begin
      rst         <= 1'b1;
      instr_valid <= 1'b0;
      instr       <= '0;
      ref_regs    = '{default: '0};
      ref_pc      = '0;
      checks0     = 0;
      errors0     = 0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      // seed r1 to r12 with the first four from r0
      for (int k = 1; k <= 12; k++) begin
         issue(make_word(9 + k % 4, (k <= 4) ? 5'd0 : 5'(k - 4), 5'(k), 5'd0,
                         16'($random(seed))));
      end
      end_test("immediate");

      for (int k = 0; k < 9; k++) begin
         issue(make_word(k, 5'(1 + $unsigned($random(seed)) % 12),
                         5'(1 + $unsigned($random(seed)) % 12), 5'(13 + k),
                         16'($random(seed))));
      end
      end_test("r-type");

      // consumer at distance d on rs and then on rt
      for (int d = 1; d <= 3; d++) begin
         issue(make_word(9, 5'd1, 5'd22, 5'd0, 16'($random(seed))));
         fill(d - 1);
         issue(make_word(0, 5'd22, 5'd14, 5'd24, 16'd0));
         fill(d - 1);
         issue(make_word(1, 5'd13, 5'd24, 5'd25, 16'd0));
      end
      repeat (3) begin
         issue(make_word(9, 5'd22, 5'd22, 5'd0, 16'($random(seed)))); // r22 in both stages
      end
      end_test("forwarding");

      issue(make_word(13, 5'd0, 5'd0, 5'd0, 16'($random(seed))));
      issue(make_word(0, 5'd31, 5'd0, 5'd27, 16'd0)); // reads r31 right behind jal
      issue(make_word(13, 5'd0, 5'd0, 5'd0, 16'($random(seed))));
      issue(make_word(13, 5'd0, 5'd0, 5'd0, 16'($random(seed))));
      end_test("jal");

      issue(make_word(9, 5'd1, 5'd0, 5'd0, 16'($random(seed))));
      issue(make_word(0, 5'd2, 5'd3, 5'd0, 16'd0));
      idle(3);
      issue(make_word(0, 5'd0, 5'd0, 5'd28, 16'd0));
      idle(2);
      issue(make_word(11, 5'd0, 5'd29, 5'd0, 16'($random(seed))));
      end_test("r0 and bubbles");

      for (int k = 0; k < n_rand; k++) begin
         issue(make_word($unsigned($random(seed)) % 14, 5'($random(seed)), 5'($random(seed)),
                         5'($random(seed)), 16'($random(seed))));
      end
      end_test("random mix");

      $display("%0d writes checked, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

/* tb.f */
src/mips_pkg.sv
src/register_file.sv
src/decode_stage.sv
src/alu_control.sv
src/alu.sv
src/forwarding_unit.sv
src/execute_stage.sv
src/mips_ex_core.sv
test/mips_ex_core_properties.sv
test/tb_mips_ex_core.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_mips_ex_core -f tb.f
	./obj_dir/Vtb_mips_ex_core | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
